// File: Makefile
# Verilator build and run of the transmit core testbench

TOP = tb_etx_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f src.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "All tests passed" run.log

clean:
	rm -rf obj_dir run.log

// File: src.f
+incdir+verilog
verilog/emesh_pkg.sv
verilog/etx_pkg.sv
verilog/priority_arbiter.sv
verilog/etx_fifo.sv
verilog/etx_arbiter.sv
verilog/etx_core.sv
verification/tb_etx_core.sv

// File: verification/etx_trace.txt
# P ch(0 wr,1 rd,2 rr) dstaddr data srcaddr ctrlmode datamode write | W cfg wr rd
# C bypass ctrlmode | I cycles | F ch wait | Q ch pending | O order on | D drain
# Mixed traffic, bypass off
P 0 80000000 a0000001 00000000 3 2 1
P 1 80000100 00000000 810f0000 6 2 0
P 2 810f0000 c0000001 00000000 9 2 1
P 0 80000004 a0000002 00000000 5 2 1
P 1 80000104 00000000 810f0004 0 1 0
P 2 810f0004 c0000002 00000000 a 1 1
P 0 80000008 a0000003 00000000 f 0 1
D
# Priority order once wr_wait and rd_wait release
W 0 1 1
P 2 810f0010 c0000010 00000000 1 2 1
P 2 810f0014 c0000011 00000000 2 2 1
P 2 810f0018 c0000012 00000000 3 2 1
P 2 810f001c c0000013 00000000 4 2 1
P 1 80000110 00000000 810f0010 2 2 0
P 1 80000114 00000000 810f0014 2 2 0
P 1 80000118 00000000 810f0018 2 2 0
P 1 8000011c 00000000 810f001c 2 2 0
P 0 80000010 a0000010 00000000 3 2 1
P 0 80000014 a0000011 00000000 3 2 1
P 0 80000018 a0000012 00000000 3 2 1
P 0 8000001c a0000013 00000000 3 2 1
I 6
Q 0 4
Q 1 4
Q 2 4
O
W 0 0 0
D
# Bypass on, responses keep ctrlmode
C 1 c
P 0 80000020 a0000020 00000000 3 2 1
P 1 80000120 00000000 810f0020 5 2 0
P 2 810f0020 c0000020 00000000 6 2 1
P 0 80000024 a0000021 00000000 0 2 1
D
C 0 0
# cfg_wait stalls everything, write buffer fills
W 1 0 0
P 0 80000030 a0000030 00000000 1 2 1
P 0 80000034 a0000031 00000000 1 2 1
P 0 80000038 a0000032 00000000 1 2 1
P 0 8000003c a0000033 00000000 1 2 1
P 1 80000130 00000000 810f0030 4 2 0
P 1 80000134 00000000 810f0034 4 2 0
I 8
F 0 1
F 1 0
Q 0 4
W 0 0 0
P 0 80000040 a0000034 00000000 1 2 1
D
# rd_wait held, writes still flow
W 0 0 1
P 1 80000140 00000000 810f0040 7 2 0
P 1 80000144 00000000 810f0044 7 2 0
P 0 80000050 a0000050 00000000 8 2 1
P 0 80000054 a0000051 00000000 8 2 1
P 0 80000058 a0000052 00000000 8 2 1
I 12
Q 0 0
Q 1 2
W 0 0 0
D
I 4

// File: verification/tb_etx_core.sv
// ############################
// Trace-driven testbench for the
// transmit core, with scoreboard
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module tb_etx_core
   import emesh_pkg::*, etx_pkg::*;
();

   typedef logic [`ETX_PW-1:0] word_t;

   localparam int PUSH_TIMEOUT  = 200;
   localparam int DRAIN_TIMEOUT = 500;

   logic          clk;
   logic          nreset;
   logic          wr_access;
   logic          rd_access;
   logic          rr_access;
   emesh_packet_t wr_packet;
   emesh_packet_t rd_packet;
   emesh_packet_t rr_packet;
   logic          wr_wait;
   logic          rd_wait;
   logic          rr_wait;
   etx_wait_t     etx_wait;
   etx_cfg_t      cfg;
   logic          etx_access;
   emesh_packet_t etx_packet;
   logic          etx_rr;

   // Scoreboard, one queue per channel
   emesh_packet_t wr_q[$];
   emesh_packet_t rd_q[$];
   emesh_packet_t rr_q[$];
   // Priority order tracking
   logic          ordered;
   int            last_ch;
   // cfg_wait seen on the previous cycle
   logic          hold_prev;
   int            delivered;

   etx_core i_dut (
      .clk        (clk),
      .nreset     (nreset),
      .wr_access  (wr_access),
      .wr_packet  (wr_packet),
      .wr_wait    (wr_wait),
      .rd_access  (rd_access),
      .rd_packet  (rd_packet),
      .rd_wait    (rd_wait),
      .rr_access  (rr_access),
      .rr_packet  (rr_packet),
      .rr_wait    (rr_wait),
      .etx_wait   (etx_wait),
      .cfg        (cfg),
      .etx_access (etx_access),
      .etx_packet (etx_packet),
      .etx_rr     (etx_rr)
   );

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ############################
   // Failure and compare
   // ############################
   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input word_t expected, input word_t actual, input string what);
      if (expected !== actual)
      begin
         $display("** Error at %0d ns: %s, expected %h, got %h",
                  $time, what, expected, actual);
         abort_run();
      end
   endtask

   // ############################
   // Channel helpers
   // ############################
   // Channel 0 write, 1 read request, 2 read response
   task automatic drive_channel(input int ch, input logic access, input emesh_packet_t pkt);
      case (ch)
         0:
         begin
            wr_access = access;
            wr_packet = pkt;
         end
         1:
         begin
            rd_access = access;
            rd_packet = pkt;
         end
         default:
         begin
            rr_access = access;
            rr_packet = pkt;
         end
      endcase
   endtask

   function automatic logic input_wait(input int ch);
      case (ch)
         0:       return wr_wait;
         1:       return rd_wait;
         default: return rr_wait;
      endcase
   endfunction

   function automatic int pending_count(input int ch);
      case (ch)
         0:       return wr_q.size();
         1:       return rd_q.size();
         default: return rr_q.size();
      endcase
   endfunction

   task automatic add_expected(input int ch, input emesh_packet_t pkt);
      case (ch)
         0:       wr_q.push_back(pkt);
         1:       rd_q.push_back(pkt);
         default: rr_q.push_back(pkt);
      endcase
   endtask

   task automatic pop_expected(input int ch, output emesh_packet_t pkt);
      case (ch)
         0:       pkt = wr_q.pop_front();
         1:       pkt = rd_q.pop_front();
         default: pkt = rr_q.pop_front();
      endcase
   endtask

   // Packet as it should leave under the current config
   function automatic emesh_packet_t predict_packet(input int ch, input emesh_packet_t pkt);
      emesh_packet_t res;
      res = pkt;
      // Read responses keep their own ctrlmode
      if (ch != 2 && cfg.ctrlmode_bypass)
         res.ctrlmode = cfg.ctrlmode;
      return res;
   endfunction

   // ############################
   // Stimulus tasks
   // ############################
   // Hold access until the buffer takes it
   task automatic push_packet(input int ch, input emesh_packet_t pkt);
      int   tries;
      logic taken;
      tries = 0;
      taken = 1'b0;
      drive_channel(ch, 1'b1, pkt);
      while (!taken)
      begin
         // Wait only changes on the rising edge
         @(negedge clk);
         if (!input_wait(ch))
         begin
            taken = 1'b1;
            add_expected(ch, predict_packet(ch, pkt));
         end
         @(posedge clk);
         #1;
         tries++;
         if (!taken && tries > PUSH_TIMEOUT)
         begin
            $display("Timeout: input wait of channel %0d stayed high", ch);
            abort_run();
         end
      end
      drive_channel(ch, 1'b0, '0);
   endtask

   task automatic drain_all();
      int cycles;
      cycles = 0;
      while (pending_count(0) + pending_count(1) + pending_count(2) != 0)
      begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > DRAIN_TIMEOUT)
         begin
            $display("Timeout: queued packets never left the transmit port");
            abort_run();
         end
      end
      ordered = 1'b0;
   endtask

   task automatic need_fields(input int code, input int n, input logic [7:0] cmd);
      if (code != n)
      begin
         $display("Malformed trace line for command %c", cmd);
         abort_run();
      end
   endtask

   // One trace command, fields follow the letter
   task automatic run_command(input int fd, input logic [7:0] cmd);
      int               code;
      int               ch;
      int               a;
      int               b;
      int               c;
      logic [31:0]      dst;
      logic [31:0]      dat;
      logic [31:0]      src;
      logic [3:0]       cm;
      logic [1:0]       dm;
      logic [8*120-1:0] line;
      emesh_packet_t    pkt;
      case (cmd)
         "#":
         begin
            code = $fgets(line, fd);
         end
         "P":
         begin
            code = $fscanf(fd, "%d %h %h %h %h %h %d", ch, dst, dat, src, cm, dm, a);
            need_fields(code, 7, cmd);
            pkt.dstaddr  = dst;
            pkt.data     = dat;
            pkt.srcaddr  = src;
            pkt.ctrlmode = cm;
            pkt.datamode = dm;
            pkt.write    = (a != 0);
            pkt.spare    = 1'b0;
            push_packet(ch, pkt);
         end
         "W":
         begin
            code = $fscanf(fd, "%d %d %d", a, b, c);
            need_fields(code, 3, cmd);
            etx_wait.cfg_wait = (a != 0);
            etx_wait.wr_wait  = (b != 0);
            etx_wait.rd_wait  = (c != 0);
         end
         "C":
         begin
            code = $fscanf(fd, "%d %h", a, cm);
            need_fields(code, 2, cmd);
            cfg.ctrlmode_bypass = (a != 0);
            cfg.ctrlmode        = cm;
         end
         "I":
         begin
            code = $fscanf(fd, "%d", a);
            need_fields(code, 1, cmd);
            repeat (a)
            begin
               @(posedge clk);
               #1;
            end
         end
         "F":
         begin
            code = $fscanf(fd, "%d %d", ch, a);
            need_fields(code, 2, cmd);
            check_value(word_t'(a != 0), word_t'(input_wait(ch)),
                        $sformatf("input wait of channel %0d", ch));
         end
         "Q":
         begin
            code = $fscanf(fd, "%d %d", ch, a);
            need_fields(code, 2, cmd);
            check_value(word_t'(a), word_t'(pending_count(ch)),
                        $sformatf("packets pending on channel %0d", ch));
         end
         "O":
         begin
            ordered = 1'b1;
            last_ch = 0;
         end
         "D":
         begin
            drain_all();
         end
         default:
         begin
            $display("Unknown trace command %c", cmd);
            abort_run();
         end
      endcase
   endtask

   // ############################
   // Output monitor
   // ############################
   always @(negedge clk)
   begin : monitor
      int            ch;
      emesh_packet_t exp_pkt;
      if (nreset)
      begin
         // One packet may still be in the register when cfg_wait rises
         if (hold_prev)
            check_value(word_t'(0), word_t'(etx_access), "etx_access during cfg_wait");
         if (etx_access)
         begin
            ch = etx_rr ? 2 : (etx_packet.write ? 0 : 1);
            if (pending_count(ch) == 0)
            begin
               $display("Unexpected packet for channel %0d at %0d ns", ch, $time);
               abort_run();
            end
            pop_expected(ch, exp_pkt);
            check_value(word_t'(exp_pkt), word_t'(etx_packet),
                        $sformatf("packet on channel %0d", ch));
            if (ordered)
               check_value(word_t'(1), word_t'(ch >= last_ch), "channel priority order");
            last_ch = ch;
            delivered++;
         end
         hold_prev = etx_wait.cfg_wait;
      end
   end

   // ############################
   // Main sequence
   // ############################
   initial
   begin
      int         fd;
      int         code;
      logic       done;
      logic [7:0] cmd;
      nreset    = 1'b0;
      wr_access = 1'b0;
      rd_access = 1'b0;
      rr_access = 1'b0;
      wr_packet = '0;
      rd_packet = '0;
      rr_packet = '0;
      etx_wait  = '0;
      cfg       = '0;
      ordered   = 1'b0;
      last_ch   = 0;
      hold_prev = 1'b0;
      delivered = 0;
      repeat (10) @(posedge clk);
      #1;
      nreset = 1'b1;

      // Idle outputs right after reset
      @(negedge clk);
      check_value(word_t'(0), word_t'(etx_access), "etx_access after reset");
      check_value(word_t'(0), word_t'(etx_rr), "etx_rr after reset");
      check_value(word_t'(0), word_t'(wr_wait), "wr_wait after reset");
      check_value(word_t'(0), word_t'(rd_wait), "rd_wait after reset");
      check_value(word_t'(0), word_t'(rr_wait), "rr_wait after reset");
      @(posedge clk);
      #1;

      fd = $fopen("verification/etx_trace.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open verification/etx_trace.txt");
         abort_run();
      end
      done = 1'b0;
      while (!done)
      begin
         code = $fscanf(fd, " %c", cmd);
         if (code != 1)
            done = 1'b1;
         else
            run_command(fd, cmd);
      end
      $fclose(fd);

      // Quiet tail catches stray packets
      repeat (10) @(posedge clk);
      $display("Delivered %0d packets", delivered);
      if (pending_count(0) + pending_count(1) + pending_count(2) != 0)
      begin
         $display("Packets were still pending at the end of the trace");
         abort_run();
      end
      else
      begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: verilog/emesh_pkg.sv
// ############################
// eMesh packet field types and
// the packed packet layout
// ############################

`default_nettype none

package emesh_pkg;

   // Field widths
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  ctrlmode_t;
   typedef logic [1:0]  datamode_t;

   // ############################
   // Packet layout, MSB first
   // ############################
   typedef struct packed {
      addr_t     dstaddr;   // 103:72
      data_t     data;      // 71:40
      addr_t     srcaddr;   // 39:8
      ctrlmode_t ctrlmode;  // 7:4
      datamode_t datamode;  // 3:2
      logic      write;     // 1
      logic      spare;     // 0
   } emesh_packet_t;

endpackage

`default_nettype wire

// File: verilog/etx_arbiter.sv
// ############################
// Control-mode insertion, channel
// arbitration and output register
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module etx_arbiter
   import emesh_pkg::*, etx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   // Channel heads
   input  logic          txwr_access,
   input  logic          txrd_access,
   input  logic          txrr_access,
   input  emesh_packet_t txwr_packet,
   input  emesh_packet_t txrd_packet,
   input  emesh_packet_t txrr_packet,
   output logic          txwr_wait,
   output logic          txrd_wait,
   output logic          txrr_wait,
   // Pin waits and config
   input  etx_wait_t     etx_wait,
   input  etx_cfg_t      cfg,
   // Transmit port
   output logic          etx_access,
   output emesh_packet_t etx_packet,
   output logic          etx_rr
);

   // Channel slots, 0 is top priority
   localparam int WR = 0;
   localparam int RD = 1;
   localparam int RR = 2;

   logic [`ETX_NCH-1:0] request;
   logic [`ETX_NCH-1:0] grant;
   logic [`ETX_NCH-1:0] arb_wait;
   logic [`ETX_NCH-1:0] pin_wait;
   logic [`ETX_NCH-1:0] base_wait;
   logic [`ETX_NCH-1:0] chan_wait;
   emesh_packet_t       txwr_data;
   emesh_packet_t       txrd_data;
   emesh_packet_t       etx_mux;
   logic                access_in;
   logic                load;

   // Override ctrlmode when bypass is on
   function automatic emesh_packet_t insert_ctrlmode(emesh_packet_t pkt,
                                                     etx_cfg_t c);
      emesh_packet_t res;
      res = pkt;
      if (c.ctrlmode_bypass)
      begin
         res.ctrlmode = c.ctrlmode;
      end
      return res;
   endfunction

   // ############################
   // Control-mode insertion
   // ############################
   // Read responses pass untouched
   assign txwr_data = insert_ctrlmode(txwr_packet, cfg);
   assign txrd_data = insert_ctrlmode(txrd_packet, cfg);

   // ############################
   // Arbitration and mux
   // ############################
   assign request = {txrr_access, txrd_access, txwr_access};

   priority_arbiter #(
      .N       (`ETX_NCH)
   ) i_prio (
      .request (request),
      .grant   (grant),
      .await   (arb_wait)
   );

   // Grant is one-hot
   always_comb
   begin
      etx_mux = '0;
      if (grant[WR])
         etx_mux = txwr_data;
      else if (grant[RD])
         etx_mux = txrd_data;
      else if (grant[RR])
         etx_mux = txrr_packet;
   end

   // ############################
   // Wait steering
   // ############################
   // Responses go out on the write lane, hence wr_wait
   assign pin_wait[WR] = etx_wait.wr_wait | etx_wait.cfg_wait;
   assign pin_wait[RD] = etx_wait.rd_wait | etx_wait.cfg_wait;
   assign pin_wait[RR] = etx_wait.wr_wait | etx_wait.cfg_wait;

   // arb_wait never rises for the write slot
   assign base_wait = pin_wait | arb_wait;

   // Granted channel ready to move
   assign access_in = |(grant & ~base_wait);

   // Stall by the kind of the chosen packet
   assign load = access_in &
                 (etx_mux.write ? ~etx_wait.wr_wait : ~etx_wait.rd_wait);

   // No pop on the granted channel unless the register takes it
   assign chan_wait = base_wait | (grant & {`ETX_NCH{~load}});

   assign txwr_wait = chan_wait[WR];
   assign txrd_wait = chan_wait[RD];
   assign txrr_wait = chan_wait[RR];

   // ############################
   // Output register
   // ############################
   // Access is a one-cycle strobe per packet
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         etx_access <= 1'b0;
         etx_rr     <= 1'b0;
      end
      else
      begin
         etx_access <= load;
         etx_rr     <= load & grant[RR];
      end
   end

   // Payload holds between loads
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         etx_packet <= etx_mux;
      end
   end

endmodule

`default_nettype wire

// File: verilog/etx_core.sv
// ############################
// Transmit top: three channel
// buffers and the arbiter
// ############################

`timescale 1ns/1ps
`default_nettype none

module etx_core
   import emesh_pkg::*, etx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   // Host writes
   input  logic          wr_access,
   input  emesh_packet_t wr_packet,
   output logic          wr_wait,
   // Host read requests
   input  logic          rd_access,
   input  emesh_packet_t rd_packet,
   output logic          rd_wait,
   // Read responses
   input  logic          rr_access,
   input  emesh_packet_t rr_packet,
   output logic          rr_wait,
   // Pin waits and config
   input  etx_wait_t     etx_wait,
   input  etx_cfg_t      cfg,
   // Transmit port
   output logic          etx_access,
   output emesh_packet_t etx_packet,
   output logic          etx_rr
);

   // Buffer heads toward the arbiter
   logic          txwr_access;
   logic          txrd_access;
   logic          txrr_access;
   emesh_packet_t txwr_packet;
   emesh_packet_t txrd_packet;
   emesh_packet_t txrr_packet;
   logic          txwr_wait;
   logic          txrd_wait;
   logic          txrr_wait;

   // ############################
   // Channel buffers
   // ############################
   etx_fifo i_wr_fifo (
      .clk        (clk),
      .nreset     (nreset),
      .in_access  (wr_access),
      .in_packet  (wr_packet),
      .in_wait    (wr_wait),
      .out_access (txwr_access),
      .out_packet (txwr_packet),
      .out_wait   (txwr_wait)
   );

   etx_fifo i_rd_fifo (
      .clk        (clk),
      .nreset     (nreset),
      .in_access  (rd_access),
      .in_packet  (rd_packet),
      .in_wait    (rd_wait),
      .out_access (txrd_access),
      .out_packet (txrd_packet),
      .out_wait   (txrd_wait)
   );

   etx_fifo i_rr_fifo (
      .clk        (clk),
      .nreset     (nreset),
      .in_access  (rr_access),
      .in_packet  (rr_packet),
      .in_wait    (rr_wait),
      .out_access (txrr_access),
      .out_packet (txrr_packet),
      .out_wait   (txrr_wait)
   );

   // ############################
   // Arbiter and output stage
   // ############################
   etx_arbiter i_arbiter (
      .clk         (clk),
      .nreset      (nreset),
      .txwr_access (txwr_access),
      .txrd_access (txrd_access),
      .txrr_access (txrr_access),
      .txwr_packet (txwr_packet),
      .txrd_packet (txrd_packet),
      .txrr_packet (txrr_packet),
      .txwr_wait   (txwr_wait),
      .txrd_wait   (txrd_wait),
      .txrr_wait   (txrr_wait),
      .etx_wait    (etx_wait),
      .cfg         (cfg),
      .etx_access  (etx_access),
      .etx_packet  (etx_packet),
      .etx_rr      (etx_rr)
   );

endmodule

`default_nettype wire

// File: verilog/etx_fifo.sv
// ############################
// Show-ahead packet buffer for
// one transmit channel
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module etx_fifo
   import emesh_pkg::*;
#(
   parameter int DEPTH = `ETX_FIFO_DEPTH
)
(
   input  logic          clk,
   input  logic          nreset,
   // Source side
   input  logic          in_access,
   input  emesh_packet_t in_packet,
   output logic          in_wait,
   // Arbiter side
   output logic          out_access,
   output emesh_packet_t out_packet,
   input  logic          out_wait
);

   localparam int AW = $clog2(DEPTH);

   // Extra MSB tells full from empty
   typedef logic [AW:0] ptr_t;

   logic [`ETX_PW-1:0] mem [DEPTH];
   ptr_t               wr_ptr;
   ptr_t               rd_ptr;
   logic               full;
   logic               empty;
   logic               push;
   logic               pop;

   // ############################
   // Status
   // ############################
   assign empty = (wr_ptr == rd_ptr);
   // Same index, lap bit differs
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   // Source is held off while full
   assign in_wait = full;
   assign push    = in_access & ~full;

   // Head is visible whenever something is stored
   assign out_access = ~empty;
   assign out_packet = emesh_packet_t'(mem[rd_ptr[AW-1:0]]);
   assign pop        = out_access & ~out_wait;

   // ############################
   // Storage
   // ############################
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr[AW-1:0]] <= in_packet;
      end
   end

   // Pointers
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/etx_macros.svh
// ############################
// Transmit path sizing: packet width,
// channel buffer depth, channel count
// ############################

`ifndef ETX_MACROS_SVH
`define ETX_MACROS_SVH

// Full eMesh packet in bits
`define ETX_PW 104

// Entries per channel buffer
// Keep this a power of two
`define ETX_FIFO_DEPTH 4

// Write, read request, read response
`define ETX_NCH 3

`endif

// File: verilog/etx_pkg.sv
// ############################
// Transmit control types: config
// and pin-side wait lines
// ############################

`default_nettype none

package etx_pkg;

   import emesh_pkg::*;

   // Control-mode override for wr/rd traffic
   typedef struct packed {
      logic      ctrlmode_bypass;
      ctrlmode_t ctrlmode;
   } etx_cfg_t;

   // Wait levels from the pin side
   typedef struct packed {
      logic cfg_wait;
      logic wr_wait;
      logic rd_wait;
   } etx_wait_t;

endpackage

`default_nettype wire

// File: verilog/priority_arbiter.sv
// ############################
// Fixed-priority arbiter with
// per-requester wait
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module priority_arbiter #(
   parameter int N = `ETX_NCH
)
(
   input  logic [N-1:0] request,
   output logic [N-1:0] grant,
   output logic [N-1:0] await
);

   // Index 0 wins, walk upward
   always_comb
   begin
      logic blocked;
      blocked = 1'b0;
      for (int i = 0; i < N; i++)
      begin
         grant[i] = request[i] & ~blocked;
         // Lost to a higher-priority requester
         await[i] = request[i] & blocked;
         blocked  = blocked | request[i];
      end
   end

endmodule

`default_nettype wire
